// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int WAYS           = 4;
    localparam int SETS           = 16;
    localparam int LINE_BITS      = 512;
    localparam int WORDS_PER_LINE = 16;
    localparam int TAG_BITS       = 22;

    // Access size codes, one bit per byte lane.
    localparam logic [3:0] SIZE_BYTE = 4'b0001;
    localparam logic [3:0] SIZE_HALF = 4'b0011;
    localparam logic [3:0] SIZE_WORD = 4'b1111;

    // Controller state codes.
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_LOOKUP    = 3'd1;
    localparam logic [2:0] ST_WRITEBACK = 3'd2;
    localparam logic [2:0] ST_REFILL    = 3'd3;
    localparam logic [2:0] ST_INSTALL   = 3'd4;
    localparam logic [2:0] ST_RELOOK    = 3'd5;
    localparam logic [2:0] ST_UNCACHED  = 3'd6;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_BITS-1:0] tag;
            logic [3:0]          index;
            logic [3:0]          word;
            logic [1:0]          byte_off;
        } fields;
    } dcache_addr_u;

endpackage

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps

module dcache_tag_array import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_en,
    input  dcache_addr_u        addr,
    input  logic                fill_en,
    input  logic [3:0]          fill_way,
    input  logic                set_dirty,
    input  logic [3:0]          dirty_way,
    output logic [3:0]          hit_way,
    output logic                hit,
    output logic [3:0]          victim_way,
    output logic                victim_dirty,
    output logic [TAG_BITS-1:0] victim_tag
);

    logic [TAG_BITS-1:0]       tag_mem [WAYS][SETS];
    logic [SETS-1:0][WAYS-1:0] valid_bits;
    logic [SETS-1:0][WAYS-1:0] dirty_bits;
    logic [SETS-1:0][1:0]      rr_ptr;

    logic [TAG_BITS-1:0] tag_q [WAYS];
    logic [TAG_BITS-1:0] ctag_q;                // Tag of the access.
    logic [WAYS-1:0]     valid_q;
    logic [WAYS-1:0]     dirty_q;
    logic [3:0]          set_q;
    logic [1:0]          victim_idx;

    always_ff @(posedge clk) begin
        if (rd_en) begin
            ctag_q <= addr.fields.tag;
            for (int w = 0; w < WAYS; w++) begin
                tag_q[w] <= tag_mem[w][addr.fields.index];
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (fill_en && fill_way[w]) begin
                tag_mem[w][set_q] <= ctag_q;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            rr_ptr     <= '0;
            valid_q    <= '0;
            dirty_q    <= '0;
            set_q      <= '0;
        end else begin
            if (rd_en) begin
                set_q   <= addr.fields.index;
                valid_q <= valid_bits[addr.fields.index];
                dirty_q <= dirty_bits[addr.fields.index];
            end
            if (fill_en) begin
                valid_bits[set_q] <= valid_bits[set_q] | fill_way;
                dirty_bits[set_q] <= dirty_bits[set_q] & ~fill_way;
                rr_ptr[set_q]     <= rr_ptr[set_q] + 2'd1;
            end else if (set_dirty) begin
                dirty_bits[set_q] <= dirty_bits[set_q] | dirty_way;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == ctag_q);
        end
    end

    assign hit = |hit_way;

    // Lowest invalid way wins over the round-robin pointer.
    always_comb begin
        victim_idx = rr_ptr[set_q];
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid_q[w]) victim_idx = 2'(w);
        end
    end

    assign victim_way   = 4'b0001 << victim_idx;
    assign victim_dirty = valid_q[victim_idx] && dirty_q[victim_idx];
    assign victim_tag   = tag_q[victim_idx];

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit_way));

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps

module dcache_data_array import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      rd_en,
    input  logic [3:0]                index,
    input  logic                      we_word,
    input  logic                      we_line,
    input  logic [3:0]                way,
    input  logic [3:0]                word,
    input  logic [3:0]                wstrb,
    input  logic [31:0]               wdata,
    input  logic [LINE_BITS-1:0]      wline,
    output logic [WAYS*LINE_BITS-1:0] mem_dout
);

    logic [LINE_BITS-1:0] lines [WAYS][SETS];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < WAYS; w++) begin
                mem_dout[w*LINE_BITS +: LINE_BITS] <= lines[w][index];
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (way[w]) begin
                if (we_line) begin
                    lines[w][index] <= wline;
                end else if (we_word) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            lines[w][index][int'(word)*32 + b*8 +: 8] <= wdata[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== mem_rd_ctrl_d.sv ====
`timescale 1ns/1ps

module mem_rd_ctrl_d import dcache_pkg::*; (
    input  dcache_addr_u               addr_rbuf,
    input  logic [31:0]                w_data_cpu,
    input  logic [3:0]                 r_way_sel,
    input  logic [WAYS*LINE_BITS-1:0]  mem_dout,
    input  logic [LINE_BITS-1:0]       r_data_mem_line,
    input  logic                       r_data_sel,
    input  logic [3:0]                 read_type_rbuf,
    input  logic                       uncache_rbuf,
    input  logic                       signed_ext,
    input  logic [3:0]                 miss_way_sel,
    output logic [LINE_BITS-1:0]       miss_sel_data,
    output logic [31:0]                r_data
);

    logic [LINE_BITS-1:0]            way_data;
    logic [WORDS_PER_LINE-1:0][31:0] hit_words;
    logic [WORDS_PER_LINE-1:0][31:0] fill_words;
    logic [31:0]                     r_data_mem;
    logic [31:0]                     r_word_fill;
    logic [31:0]                     r_data_word;

    always_comb begin
        case (r_way_sel)
            4'b0001: way_data = mem_dout[511:0];
            4'b0010: way_data = mem_dout[1023:512];
            4'b0100: way_data = mem_dout[1535:1024];
            4'b1000: way_data = mem_dout[2047:1536];
            default: way_data = '0;
        endcase
    end

    assign hit_words  = way_data;
    assign fill_words = r_data_mem_line;
    assign r_data_mem = hit_words[addr_rbuf.fields.word];

    // Uncached data always arrives in word zero.
    assign r_word_fill = uncache_rbuf ? fill_words[0] : fill_words[addr_rbuf.fields.word];
    assign r_data_word = r_data_sel ? r_data_mem : r_word_fill;

    always_comb begin
        case (read_type_rbuf)
            SIZE_BYTE: begin
                case (addr_rbuf.fields.byte_off)
                    2'd0: r_data = {{24{r_data_word[7] & signed_ext}}, r_data_word[7:0]};
                    2'd1: r_data = {{24{r_data_word[15] & signed_ext}}, r_data_word[15:8]};
                    2'd2: r_data = {{24{r_data_word[23] & signed_ext}}, r_data_word[23:16]};
                    2'd3: r_data = {{24{r_data_word[31] & signed_ext}}, r_data_word[31:24]};
                endcase
            end
            SIZE_HALF: begin
                case (addr_rbuf.fields.byte_off)
                    2'd0: r_data = {{16{r_data_word[15] & signed_ext}}, r_data_word[15:0]};
                    2'd2: r_data = {{16{r_data_word[31] & signed_ext}}, r_data_word[31:16]};
                    default: r_data = '0;
                endcase
            end
            SIZE_WORD: r_data = r_data_word;
            default:   r_data = '0;
        endcase
    end

    always_comb begin
        if (uncache_rbuf) begin
            miss_sel_data = {480'b0, w_data_cpu};
        end else begin
            case (miss_way_sel)
                4'b0001: miss_sel_data = mem_dout[511:0];
                4'b0010: miss_sel_data = mem_dout[1023:512];
                4'b0100: miss_sel_data = mem_dout[1535:1024];
                4'b1000: miss_sel_data = mem_dout[2047:1536];
                default: miss_sel_data = '0;
            endcase
        end
    end

    // A hit selected by the controller always names exactly one way.
    always_comb begin
        a_way_onehot: assert final (r_data_sel !== 1'b1 || $onehot(r_way_sel));
    end

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [31:0]         paddr,
    input  logic [31:0]         pwdata,
    input  logic [3:0]          pstrb,
    input  logic [3:0]          size,
    input  logic                signed_ext,
    input  logic                uncache,
    input  logic                hit,
    input  logic [3:0]          hit_way,
    input  logic [3:0]          victim_way,
    input  logic                victim_dirty,
    input  logic [TAG_BITS-1:0] victim_tag,
    input  logic                mem_ack,
    output logic                pready,
    output logic                pslverr,
    output logic                rd_en,
    output logic                fill_en,
    output logic [3:0]          fill_way,
    output logic                set_dirty,
    output logic                we_word,
    output logic                we_line,
    output logic                r_data_sel,
    output logic [3:0]          miss_way_sel,
    output logic [3:0]          r_way_sel,
    output dcache_addr_u        addr_rbuf,
    output logic [3:0]          read_type_rbuf,
    output logic                uncache_rbuf,
    output logic                signed_rbuf,
    output logic [31:0]         wdata_rbuf,
    output logic [3:0]          wstrb_rbuf,
    output logic                mem_req,
    output logic                mem_we,
    output logic [31:0]         mem_addr
);

    logic [2:0]   state;
    dcache_addr_u req_addr;
    logic         setup;
    logic         misalign;
    logic         err_q;
    logic         write_q;
    logic         lookup_hit;
    logic [31:0]  line_addr;

    assign req_addr.raw = paddr;
    assign setup        = psel && !penable;
    assign line_addr    = {addr_rbuf.fields.tag, addr_rbuf.fields.index, 6'b0};

    always_comb begin
        case (size)
            SIZE_BYTE: misalign = 1'b0;
            SIZE_HALF: misalign = req_addr.fields.byte_off[0];
            SIZE_WORD: misalign = |req_addr.fields.byte_off;
            default:   misalign = 1'b1;              // Illegal size code.
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && setup) begin
            addr_rbuf      <= req_addr;
            read_type_rbuf <= size;
            uncache_rbuf   <= uncache;
            signed_rbuf    <= signed_ext;
            wdata_rbuf     <= pwdata;
            wstrb_rbuf     <= pstrb;
            write_q        <= pwrite;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            err_q        <= 1'b0;
            miss_way_sel <= '0;
            mem_req      <= 1'b0;
            mem_we       <= 1'b0;
            mem_addr     <= '0;
        end else begin
            case (state)
                ST_IDLE: if (setup) begin
                    err_q <= misalign;
                    if (!misalign && uncache) begin
                        mem_req  <= 1'b1;
                        mem_we   <= pwrite;
                        mem_addr <= {paddr[31:2], 2'b00};
                        state    <= ST_UNCACHED;
                    end else begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: if (err_q || hit) begin
                    state <= ST_IDLE;
                end else begin
                    miss_way_sel <= victim_way;
                    mem_req      <= 1'b1;
                    if (victim_dirty) begin
                        mem_we   <= 1'b1;
                        mem_addr <= {victim_tag, addr_rbuf.fields.index, 6'b0};
                        state    <= ST_WRITEBACK;
                    end else begin
                        mem_we   <= 1'b0;
                        mem_addr <= line_addr;
                        state    <= ST_REFILL;
                    end
                end
                ST_WRITEBACK: if (mem_ack) begin
                    mem_we   <= 1'b0;                    // Refill follows directly.
                    mem_addr <= line_addr;
                    state    <= ST_REFILL;
                end
                ST_REFILL: if (mem_ack) begin
                    mem_req <= 1'b0;
                    state   <= ST_INSTALL;
                end
                ST_INSTALL: state <= ST_RELOOK;
                ST_RELOOK:  state <= ST_LOOKUP;
                ST_UNCACHED: if (mem_ack) begin
                    mem_req <= 1'b0;
                    mem_we  <= 1'b0;
                    state   <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign lookup_hit = (state == ST_LOOKUP) && !err_q && hit;

    assign rd_en      = (state == ST_IDLE && setup && !uncache && !misalign) ||
                        (state == ST_RELOOK);
    assign pready     = (state == ST_LOOKUP && (err_q || hit)) ||
                        (state == ST_UNCACHED && mem_ack);
    assign pslverr    = (state == ST_LOOKUP) && err_q;
    assign we_word    = lookup_hit && write_q;
    assign set_dirty  = we_word;
    assign we_line    = (state == ST_REFILL) && mem_ack;  // Line is only valid on ack.
    assign fill_en    = (state == ST_INSTALL);
    assign fill_way   = miss_way_sel;
    assign r_data_sel = lookup_hit;
    assign r_way_sel  = (state == ST_LOOKUP) ? hit_way : miss_way_sel;

    a_mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we));

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          paddr,
    input  logic [31:0]          pwdata,
    input  logic [3:0]           pstrb,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic [3:0]           size,
    input  logic                 signed_ext,
    input  logic                 uncache,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic [31:0]          mem_addr,
    output logic [LINE_BITS-1:0] mem_wline,
    input  logic [LINE_BITS-1:0] mem_rline,
    input  logic                 mem_ack
);

    dcache_addr_u              cpu_addr;
    dcache_addr_u              addr_rbuf;
    logic                      rd_en, fill_en, set_dirty, we_word, we_line;
    logic                      hit, victim_dirty, r_data_sel;
    logic                      uncache_rbuf, signed_rbuf;
    logic [3:0]                hit_way, victim_way, fill_way, miss_way_sel, r_way_sel;
    logic [3:0]                read_type_rbuf, wstrb_rbuf;
    logic [TAG_BITS-1:0]       victim_tag;
    logic [31:0]               wdata_rbuf;
    logic [WAYS*LINE_BITS-1:0] mem_dout;

    assign cpu_addr.raw = paddr;                      // Arrays index off the live address.

    dcache_ctrl u_ctrl (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb,
        .size, .signed_ext, .uncache, .hit, .hit_way, .victim_way, .victim_dirty,
        .victim_tag, .mem_ack, .pready, .pslverr, .rd_en, .fill_en, .fill_way,
        .set_dirty, .we_word, .we_line, .r_data_sel, .miss_way_sel, .r_way_sel,
        .addr_rbuf, .read_type_rbuf, .uncache_rbuf, .signed_rbuf, .wdata_rbuf,
        .wstrb_rbuf, .mem_req, .mem_we, .mem_addr
    );

    dcache_tag_array u_tag (
        .clk, .rst_n, .rd_en, .addr(cpu_addr), .fill_en, .fill_way, .set_dirty,
        .dirty_way(r_way_sel), .hit_way, .hit, .victim_way, .victim_dirty, .victim_tag
    );

    dcache_data_array u_data (
        .clk, .rd_en, .index(cpu_addr.fields.index), .we_word, .we_line,
        .way(r_way_sel), .word(addr_rbuf.fields.word), .wstrb(wstrb_rbuf),
        .wdata(wdata_rbuf), .wline(mem_rline), .mem_dout
    );

    mem_rd_ctrl_d u_rd (
        .addr_rbuf, .w_data_cpu(wdata_rbuf), .r_way_sel, .mem_dout,
        .r_data_mem_line(mem_rline), .r_data_sel, .read_type_rbuf, .uncache_rbuf,
        .signed_ext(signed_rbuf), .miss_way_sel, .miss_sel_data(mem_wline), .r_data(prdata)
    );

endmodule

// ==== tb_dcache.sv ====
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*;;

    localparam int TRANSFERS      = 83;           // All APB transfers of the tests.
    localparam int MISS_CYCLES    = 16;           // Worst case of one transfer incl. writeback.
    localparam int TIMEOUT_CYCLES = TRANSFERS * MISS_CYCLES;
    localparam int MODEL_LINES    = 256;

    logic                 clk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [31:0]          paddr;
    logic [31:0]          pwdata;
    logic [3:0]           pstrb;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;
    logic [3:0]           size;
    logic                 signed_ext;
    logic                 uncache;
    logic                 mem_req;
    logic                 mem_we;
    logic [31:0]          mem_addr;
    logic [LINE_BITS-1:0] mem_wline;
    logic [LINE_BITS-1:0] mem_rline;
    logic                 mem_ack;

    logic [LINE_BITS-1:0] mem_lines [MODEL_LINES];
    logic [31:0]          ref_words [MODEL_LINES*WORDS_PER_LINE];  // CPU view of memory.
    integer               seed = 32'h9544_6946;
    int                   error_count = 0;
    int                   check_count = 0;
    int                   cycle_count = 0;
    int                   req_cycles  = 0;

    dcache_top u_dut (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .prdata,
        .pready, .pslverr, .size, .signed_ext, .uncache, .mem_req, .mem_we, .mem_addr,
        .mem_wline, .mem_rline, .mem_ack
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (mem_req === 1'b1) req_cycles++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    // Expected load result, taken by shifting the lane down to bit zero.
    function automatic logic [31:0] load_value(input logic [31:0] word, input logic [3:0] sz,
                                               input logic [1:0] off, input logic sgn);
        logic [31:0] lane;
        lane = word >> (8 * off);
        if (sz == SIZE_BYTE) return {{24{sgn & lane[7]}}, lane[7:0]};
        if (sz == SIZE_HALF) return {{16{sgn & lane[15]}}, lane[15:0]};
        return word;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) merged[b*8 +: 8] = new_word[b*8 +: 8];
        end
        return merged;
    endfunction

    // Line memory; uncached requests touch one word, addressed by mem_addr.
    initial begin
        int          delay;
        logic [7:0]  line_idx;
        logic [3:0]  word_idx;
        mem_ack   = 1'b0;
        mem_rline = '0;
        for (int i = 0; i < MODEL_LINES; i++) begin
            for (int j = 0; j < WORDS_PER_LINE; j++) begin
                mem_lines[i][j*32 +: 32] = fill_word(32'(i) * 64 + 32'(j) * 4);
            end
        end
        forever begin
            @(posedge clk);
            #2;
            mem_ack = 1'b0;
            if (mem_req === 1'b1) begin
                delay = {$random(seed)} % 3;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                line_idx = mem_addr[13:6];
                word_idx = mem_addr[5:2];
                if (uncache) begin
                    if (mem_we) mem_lines[line_idx][word_idx*32 +: 32] = mem_wline[31:0];
                    mem_rline = {480'b0, mem_lines[line_idx][word_idx*32 +: 32]};
                end else begin
                    if (mem_we) mem_lines[line_idx] = mem_wline;
                    mem_rline = mem_lines[line_idx];
                end
                mem_ack = 1'b1;
            end
        end
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic [LINE_BITS-1:0] got,
                              input logic [LINE_BITS-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                input logic [3:0] sz, input logic sgn, input logic unc,
                                output logic [31:0] rdata, output logic err,
                                output int waits);
        @(posedge clk);
        #2;
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = wr;
        paddr      = addr;
        pwdata     = wdata;
        pstrb      = strb;
        size       = sz;
        signed_ext = sgn;
        uncache    = unc;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (pready !== 1'b1) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        uncache = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, input logic [3:0] sz, input logic sgn,
                            input logic unc, output logic [31:0] rdata, output logic err,
                            output int waits);
        apb_transfer(1'b0, addr, '0, 4'h0, sz, sgn, unc, rdata, err, waits);
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, input logic unc, output logic err,
                             output int waits);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, wdata, strb, SIZE_WORD, 1'b0, unc, unused, err, waits);
    endtask

    task automatic read_and_check(input logic [31:0] addr, input logic [3:0] sz,
                                  input logic sgn, input logic expect_hit);
        logic [31:0] data;
        logic        err;
        int          waits;
        apb_read(addr, sz, sgn, 1'b0, data, err, waits);
        check_word($sformatf("prdata @%h", addr), data,
                   load_value(ref_words[addr[13:2]], sz, addr[1:0], sgn));
        check_bit("pslverr", err, 1'b0);
        if (expect_hit) check_bit("pready in first access cycle", waits == 0, 1'b1);
    endtask

    task automatic write_and_update(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [3:0] strb, input logic expect_hit);
        logic err;
        int   waits;
        apb_write(addr, wdata, strb, 1'b0, err, waits);
        ref_words[addr[13:2]] = merge_bytes(ref_words[addr[13:2]], wdata, strb);
        check_bit("pslverr", err, 1'b0);
        if (expect_hit) check_bit("store hit in first access cycle", waits == 0, 1'b1);
    endtask

    task automatic test_read_miss_line();
        read_and_check(32'h100, SIZE_WORD, 1'b0, 1'b0);
        for (int w = 1; w < WORDS_PER_LINE; w++) begin
            read_and_check(32'h100 + 32'(w) * 4, SIZE_WORD, 1'b0, 1'b1);
        end
    endtask

    task automatic test_byte_half_reads();
        logic [31:0] base;
        read_and_check(32'h20C, SIZE_WORD, 1'b0, 1'b0);
        write_and_update(32'h214, 32'hF07F_8001, 4'hF, 1'b1);   // Mixed sign bytes.
        for (int n = 0; n < 2; n++) begin
            base = n ? 32'h214 : 32'h20C;
            for (int off = 0; off < 4; off++) begin
                read_and_check(base + 32'(off), SIZE_BYTE, 1'b0, 1'b1);
                read_and_check(base + 32'(off), SIZE_BYTE, 1'b1, 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                read_and_check(base + 32'(off), SIZE_HALF, 1'b0, 1'b1);
                read_and_check(base + 32'(off), SIZE_HALF, 1'b1, 1'b1);
            end
        end
    endtask

    task automatic test_store_hits();
        logic [3:0] strobes [10] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011,
                                     4'b1100, 4'b1111, 4'b0101, 4'b1010, 4'b0000};
        read_and_check(32'h300, SIZE_WORD, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            write_and_update(32'h300 + 32'(i) * 4, $random(seed), strobes[i], 1'b1);
            read_and_check(32'h300 + 32'(i) * 4, SIZE_WORD, 1'b0, 1'b1);
        end
    endtask

    // Lines 0x400 apart share set 5; nine of them push the first five out.
    task automatic test_set_eviction();
        logic [31:0]          addr;
        logic [LINE_BITS-1:0] exp_line;
        for (int k = 0; k < 5; k++) begin
            addr = 32'h140 + 32'(k) * 32'h400 + 32'(k) * 4;
            write_and_update(addr, $random(seed), 4'hF, 1'b0);
            read_and_check(addr, SIZE_WORD, 1'b0, 1'b1);
        end
        for (int k = 5; k < 9; k++) begin
            read_and_check(32'h140 + 32'(k) * 32'h400, SIZE_WORD, 1'b0, 1'b0);
        end
        for (int k = 0; k < 5; k++) begin
            addr = 32'h140 + 32'(k) * 32'h400;
            for (int j = 0; j < WORDS_PER_LINE; j++) begin
                exp_line[j*32 +: 32] = ref_words[addr[13:6] * WORDS_PER_LINE + j];
            end
            check_line($sformatf("model line @%h", addr), mem_lines[addr[13:6]], exp_line);
        end
    endtask

    task automatic test_uncached();
        logic [31:0] data;
        logic        err;
        int          waits;
        apb_write(32'h108, 32'hC0DE_5A17, 4'hF, 1'b1, err, waits);
        check_bit("pslverr", err, 1'b0);
        check_word("model word @108", mem_lines[4][2*32 +: 32], 32'hC0DE_5A17);
        apb_read(32'h108, SIZE_WORD, 1'b0, 1'b1, data, err, waits);
        check_word("uncached prdata @108", data, 32'hC0DE_5A17);
        read_and_check(32'h108, SIZE_WORD, 1'b0, 1'b1);         // Cached copy stays old.
    endtask

    task automatic test_misaligned();
        logic [31:0] data;
        logic        err;
        int          waits;
        int          req_before;
        req_before = req_cycles;
        apb_read(32'h101, SIZE_HALF, 1'b0, 1'b0, data, err, waits);
        check_bit("pslverr misaligned half", err, 1'b1);
        check_bit("error in first access cycle", waits == 0, 1'b1);
        apb_read(32'h102, SIZE_WORD, 1'b0, 1'b0, data, err, waits);
        check_bit("pslverr misaligned word", err, 1'b1);
        check_bit("error in first access cycle", waits == 0, 1'b1);
        apb_read(32'h100, 4'b0111, 1'b0, 1'b0, data, err, waits);
        check_bit("pslverr illegal size", err, 1'b1);
        check_bit("error in first access cycle", waits == 0, 1'b1);
        check_word("mem_req cycles", 32'(req_cycles), 32'(req_before));
    endtask

    initial begin
        rst_n      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pstrb      = '0;
        size       = SIZE_WORD;
        signed_ext = 1'b0;
        uncache    = 1'b0;
        for (int i = 0; i < MODEL_LINES * WORDS_PER_LINE; i++) begin
            ref_words[i] = fill_word(32'(i) * 4);
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_read_miss_line();
        test_byte_half_reads();
        test_store_hits();
        test_set_eviction();
        test_uncached();
        test_misaligned();
        repeat (2) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
mem_rd_ctrl_d.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_tag_array.sv
  - dcache_data_array.sv
  - mem_rd_ctrl_d.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: simulation
    files:
      - tb_dcache.sv
